// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== design/pixel_compositor.sv ====
`timescale 1ns/1ps

module pixel_compositor #(
    parameter int HUD_TOP = 360
) (
    input  logic                                    clk_25MHz,
    input  logic                                    rst,
    input  logic [race_pkg::COORD_W-1:0]            h_cnt,
    input  logic [race_pkg::COORD_W-1:0]            v_cnt,
    input  logic                                    visible,
    input  logic                                    in_hud,
    input  logic                                    hsync_raw,
    input  logic                                    vsync_raw,
    input  logic [race_pkg::COORD_W-1:0]            p1_x,
    input  logic [race_pkg::COORD_W-1:0]            p1_y,
    input  logic [race_pkg::COORD_W-1:0]            p2_x,
    input  logic [race_pkg::COORD_W-1:0]            p2_y,
    input  logic [1:0]                              active,
    input  logic [1:0]                              self_hit,
    input  logic [1:0]                              enemy_hit,
    input  logic [1:0]                              out_of_map,
    input  logic [1:0][race_pkg::COLOR_IDX_W-1:0]   map_idx,
    output logic [race_pkg::RGB_W-1:0]              rgb,
    output logic                                    hsync,
    output logic                                    vsync
);
    import race_pkg::*;

    logic [COORD_W-1:0] h_s1, v_s1, h_s2, v_s2;
    logic               vis_s1, vis_s2, hud_s1, hud_s2;
    logic               hs_s1, hs_s2, vs_s1, vs_s2;
    logic [COORD_W-1:0] mm_x, mm_y;
    logic               p1_dot, p2_dot;
    logic               sel;
    logic [RGB_W-1:0]   own_col, rival_col, rgb_nxt;

    function automatic logic near(input logic [COORD_W-1:0] a, input logic [COORD_W-1:0] b);
        logic [COORD_W-1:0] d;
        d = (a >= b) ? a - b : b - a;
        return d <= COORD_W'(DOT_HALF);
    endfunction

    // raster position to stage 2, alongside the map index
    always_ff @(posedge clk_25MHz) begin
        h_s1 <= h_cnt;
        v_s1 <= v_cnt;
        h_s2 <= h_s1;
        v_s2 <= v_s1;
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            {vis_s1, vis_s2, hud_s1, hud_s2} <= 4'b0000;
            {hs_s1, hs_s2, vs_s1, vs_s2}     <= 4'b1111;
        end else begin
            {vis_s1, vis_s2, hud_s1, hud_s2} <= {visible, vis_s1, in_hud, hud_s1};
            {hs_s1, hs_s2, vs_s1, vs_s2}     <= {hsync_raw, hs_s1, vsync_raw, vs_s1};
        end
    end

    // ----------------------------------------------------------------------
    // minimap, half scale of world coordinates
    // ----------------------------------------------------------------------
    assign mm_x   = (h_s2 - COORD_W'(MM_X0)) << 1;
    assign mm_y   = (v_s2 - COORD_W'(HUD_TOP)) << 1;
    assign p1_dot = near(mm_x, p1_x) && near(mm_y, p1_y);
    assign p2_dot = near(mm_x, p2_x) && near(mm_y, p2_y);

    // right half belongs to p2
    assign sel       = active[1];
    assign own_col   = sel ? COL_P2 : COL_P1;
    assign rival_col = sel ? COL_P1 : COL_P2;

    // layer priority
    always_comb begin
        if (!vis_s2) begin
            rgb_nxt = COL_BLANK;
        end else if (v_s2 == COORD_W'(HUD_TOP - 1) || v_s2 == COORD_W'(HUD_TOP)) begin
            rgb_nxt = COL_SEPARATOR;
        end else if (hud_s2) begin
            if (h_s2 >= COORD_W'(MM_X0) && h_s2 < COORD_W'(MM_X1)) begin
                rgb_nxt = p1_dot ? COL_P1 : (p2_dot ? COL_P2 : COL_HUD);
            end else begin
                rgb_nxt = COL_HUD;
            end
        end else if (h_s2 == COORD_W'(VIEW_W - 1) || h_s2 == COORD_W'(VIEW_W)) begin
            rgb_nxt = COL_SEPARATOR;
        end else if (!(active[0] || active[1])) begin
            rgb_nxt = COL_BLANK;
        end else if (self_hit[sel]) begin
            rgb_nxt = own_col;
        end else if (enemy_hit[sel]) begin
            rgb_nxt = rival_col;
        end else if (out_of_map[sel]) begin
            rgb_nxt = COL_OUT_BOUND;
        end else begin
            rgb_nxt = palette(map_idx[sel]);
        end
    end

    // stage 3 VGA outputs
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            rgb   <= COL_BLANK;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= rgb_nxt;
            hsync <= hs_s2;
            vsync <= vs_s2;
        end
    end

endmodule

// ==== design/player_view.sv ====
`timescale 1ns/1ps

module player_view #(
    parameter int VIEW_ID = 0
) (
    input  logic                              clk_25MHz,
    input  logic                              rst,
    input  logic [race_pkg::COORD_W-1:0]      h_cnt,
    input  logic [race_pkg::COORD_W-1:0]      v_cnt,
    input  logic [race_pkg::COORD_W-1:0]      own_x,
    input  logic [race_pkg::COORD_W-1:0]      own_y,
    input  logic [race_pkg::COORD_W-1:0]      other_x,
    input  logic [race_pkg::COORD_W-1:0]      other_y,
    output logic [race_pkg::MAP_ADDR_W-1:0]   map_addr,
    output logic                              active,
    output logic                              self_hit,
    output logic                              enemy_hit,
    output logic                              out_of_map
);
    import race_pkg::*;

    // signed width for the rival box, room for 8x a full coordinate swing
    localparam int BOX_W = COORD_W + 5;
    localparam logic [COORD_W-1:0]      X_BASE = COORD_W'(VIEW_ID * VIEW_W);
    localparam logic [COORD_W-1:0]      X_END  = COORD_W'(VIEW_ID * VIEW_W + VIEW_W);
    localparam logic signed [BOX_W-1:0] HALF_S = BOX_W'(CAR_HALF);
    localparam logic signed [BOX_W-1:0] CX_S   = BOX_W'(ENEMY_CX);
    localparam logic signed [BOX_W-1:0] CY_S   = BOX_W'(ENEMY_CY);

    logic [COORD_W-1:0]      rel_x;
    logic [COORD_W-1:0]      cell_x;
    logic [COORD_W-1:0]      cell_y;
    logic [MAP_ADDR_W-1:0]   row_base;
    logic [MAP_ADDR_W-1:0]   addr_c;
    logic                    in_view;
    logic                    oob_c;
    logic                    self_c;
    logic                    enemy_c;
    logic signed [BOX_W-1:0] dx, dy;
    logic signed [BOX_W-1:0] ecx, ecy;
    logic signed [BOX_W-1:0] px, py;
    logic                    active_s1, self_s1, enemy_s1, oob_s1;

    // ----------------------------------------------------------------------
    // map cell under the pixel
    // ----------------------------------------------------------------------
    assign in_view = (h_cnt >= X_BASE) && (h_cnt < X_END) && (v_cnt < COORD_W'(V_VISIBLE));
    assign rel_x   = h_cnt - X_BASE;

    // window corner sits VIEW_OFS cells up-left of the player
    assign cell_x = (rel_x >> CELL_SHIFT) + own_x - COORD_W'(VIEW_OFS_X);
    assign cell_y = (v_cnt >> CELL_SHIFT) + own_y - COORD_W'(VIEW_OFS_Y);
    assign oob_c  = (cell_x >= COORD_W'(MAP_W)) || (cell_y >= COORD_W'(MAP_H));

    // row * 320 as row * 256 + row * 64
    assign row_base = (MAP_ADDR_W'(cell_y) << 8) + (MAP_ADDR_W'(cell_y) << 6);
    assign addr_c   = oob_c ? '0 : row_base + MAP_ADDR_W'(cell_x);

    // ----------------------------------------------------------------------
    // car boxes
    // ----------------------------------------------------------------------
    assign self_c = (rel_x >= COORD_W'(SELF_X0)) && (rel_x <= COORD_W'(SELF_X1)) &&
                    (v_cnt >= COORD_W'(SELF_Y0)) && (v_cnt <= COORD_W'(SELF_Y1));

    // rival offset, one world unit is one cell on screen
    assign dx  = $signed({{(BOX_W - COORD_W){1'b0}}, other_x}) -
                 $signed({{(BOX_W - COORD_W){1'b0}}, own_x});
    assign dy  = $signed({{(BOX_W - COORD_W){1'b0}}, other_y}) -
                 $signed({{(BOX_W - COORD_W){1'b0}}, own_y});
    assign ecx = CX_S + (dx <<< CELL_SHIFT);
    assign ecy = CY_S + (dy <<< CELL_SHIFT);
    assign px  = $signed({{(BOX_W - COORD_W){1'b0}}, rel_x});
    assign py  = $signed({{(BOX_W - COORD_W){1'b0}}, v_cnt});

    assign enemy_c = (px >= ecx - HALF_S) && (px <= ecx + HALF_S) &&
                     (py >= ecy - HALF_S) && (py <= ecy + HALF_S);

    // stage 1 address and flags, stage 2 flags meet the returned index
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            map_addr   <= '0;
            active_s1  <= 1'b0;
            self_s1    <= 1'b0;
            enemy_s1   <= 1'b0;
            oob_s1     <= 1'b0;
            active     <= 1'b0;
            self_hit   <= 1'b0;
            enemy_hit  <= 1'b0;
            out_of_map <= 1'b0;
        end else begin
            map_addr   <= addr_c;
            active_s1  <= in_view;
            self_s1    <= self_c;
            enemy_s1   <= enemy_c;
            oob_s1     <= oob_c;
            active     <= active_s1;
            self_hit   <= self_s1;
            enemy_hit  <= enemy_s1;
            out_of_map <= oob_s1;
        end
    end

endmodule

// ==== design/race_pkg.sv ====
package race_pkg;

    // ----------------------------------------------------------------------
    // raster geometry, 640x480 at 25 MHz pixel clock
    // ----------------------------------------------------------------------
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_TOTAL   = 800;
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 525;

    // view and map layout
    localparam int VIEW_W      = 320;
    localparam int MAP_W       = 320;
    localparam int MAP_H       = 240;
    localparam int MAP_ADDR_W  = 17;
    localparam int COORD_W     = 10;
    localparam int COLOR_IDX_W = 4;
    localparam int RGB_W       = 12;
    localparam int CELL_SHIFT  = 3;
    localparam int VIEW_OFS_X  = 20;
    localparam int VIEW_OFS_Y  = 22;

    // car boxes, view-relative pixels
    localparam int SELF_X0  = 123;
    localparam int SELF_X1  = 197;
    localparam int SELF_Y0  = 143;
    localparam int SELF_Y1  = 217;
    localparam int ENEMY_CX = 160;
    localparam int ENEMY_CY = 180;
    localparam int CAR_HALF = 37;

    // minimap
    localparam int DOT_HALF = 4;
    localparam int MM_X0    = 240;
    localparam int MM_X1    = 400;

    // fixed colours
    localparam logic [RGB_W-1:0] COL_BLANK     = 12'h000;
    localparam logic [RGB_W-1:0] COL_SEPARATOR = 12'hFFF;
    localparam logic [RGB_W-1:0] COL_OUT_BOUND = 12'h6B4;
    localparam logic [RGB_W-1:0] COL_HUD       = 12'h444;
    localparam logic [RGB_W-1:0] COL_P1        = 12'hF00;
    localparam logic [RGB_W-1:0] COL_P2        = 12'h00F;

    // map index to colour
    function automatic logic [RGB_W-1:0] palette(input logic [COLOR_IDX_W-1:0] idx);
        logic [RGB_W-1:0] c;
        case (idx)
            4'd0:  c = 12'h3A3;
            4'd1:  c = 12'h555;
            4'd2:  c = 12'h777;
            4'd3:  c = 12'hD22;
            4'd4:  c = 12'hEEE;
            4'd5:  c = 12'hDC8;
            4'd6:  c = 12'h38C;
            4'd7:  c = 12'h252;
            4'd8:  c = 12'h963;
            4'd9:  c = 12'hFD0;
            4'd10: c = 12'h888;
            4'd11: c = 12'h5C5;
            4'd12: c = 12'hA4A;
            4'd13: c = 12'h0CC;
            4'd14: c = 12'h333;
            default: c = 12'hF80;
        endcase
        return c;
    endfunction

endpackage

// ==== design/scan_timing.sv ====
`timescale 1ns/1ps

module scan_timing #(
    parameter int HUD_TOP = 360
) (
    input  logic                                 clk_25MHz,
    input  logic                                 rst,
    input  logic [race_pkg::COORD_W-1:0]         p1_x,
    input  logic [race_pkg::COORD_W-1:0]         p1_y,
    input  logic [race_pkg::COORD_W-1:0]         p2_x,
    input  logic [race_pkg::COORD_W-1:0]         p2_y,
    output logic [race_pkg::COORD_W-1:0]         h_cnt,
    output logic [race_pkg::COORD_W-1:0]         v_cnt,
    output logic                                 visible,
    output logic                                 in_hud,
    output logic                                 hsync_raw,
    output logic                                 vsync_raw,
    output logic [1:0][race_pkg::COORD_W-1:0]    own_x,
    output logic [1:0][race_pkg::COORD_W-1:0]    own_y,
    output logic [1:0][race_pkg::COORD_W-1:0]    other_x,
    output logic [1:0][race_pkg::COORD_W-1:0]    other_y
);
    import race_pkg::*;

    localparam logic [COORD_W-1:0] HS_START = COORD_W'(H_VISIBLE + H_FRONT);
    localparam logic [COORD_W-1:0] HS_END   = COORD_W'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam logic [COORD_W-1:0] VS_START = COORD_W'(V_VISIBLE + V_FRONT);
    localparam logic [COORD_W-1:0] VS_END   = COORD_W'(V_VISIBLE + V_FRONT + V_SYNC);

    logic [COORD_W-1:0] h_nxt;
    logic [COORD_W-1:0] v_nxt;
    logic               line_end;
    logic               frame_end;
    logic [COORD_W-1:0] p1_x_l, p1_y_l, p2_x_l, p2_y_l;

    // ----------------------------------------------------------------------
    // raster counters
    // ----------------------------------------------------------------------
    assign line_end  = (h_cnt == COORD_W'(H_TOTAL - 1));
    assign frame_end = line_end && (v_cnt == COORD_W'(V_TOTAL - 1));
    assign h_nxt     = line_end ? '0 : h_cnt + 1'b1;

    always_comb begin
        if (frame_end) begin
            v_nxt = '0;
        end else if (line_end) begin
            v_nxt = v_cnt + 1'b1;
        end else begin
            v_nxt = v_cnt;
        end
    end

    // flags come from the next position so they line up with the counters
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            visible   <= 1'b1;
            in_hud    <= 1'b0;
            hsync_raw <= 1'b1;
            vsync_raw <= 1'b1;
        end else begin
            h_cnt     <= h_nxt;
            v_cnt     <= v_nxt;
            visible   <= (h_nxt < COORD_W'(H_VISIBLE)) && (v_nxt < COORD_W'(V_VISIBLE));
            in_hud    <= (v_nxt > COORD_W'(HUD_TOP)) && (v_nxt < COORD_W'(V_VISIBLE));
            // active-low syncs
            hsync_raw <= !((h_nxt >= HS_START) && (h_nxt < HS_END));
            vsync_raw <= !((v_nxt >= VS_START) && (v_nxt < VS_END));
        end
    end

    // ----------------------------------------------------------------------
    // positions held for a whole frame
    // ----------------------------------------------------------------------
    // also loaded during reset so frame 0 starts with valid positions
    always_ff @(posedge clk_25MHz) begin
        if (rst || frame_end) begin
            p1_x_l <= p1_x;
            p1_y_l <= p1_y;
            p2_x_l <= p2_x;
            p2_y_l <= p2_y;
        end
    end

    // view 0 follows p1, view 1 follows p2
    assign own_x[0]   = p1_x_l;
    assign own_y[0]   = p1_y_l;
    assign other_x[0] = p2_x_l;
    assign other_y[0] = p2_y_l;
    assign own_x[1]   = p2_x_l;
    assign own_y[1]   = p2_y_l;
    assign other_x[1] = p1_x_l;
    assign other_y[1] = p1_y_l;

endmodule

// ==== design/split_screen_top.sv ====
`timescale 1ns/1ps

module split_screen_top #(
    parameter int HUD_TOP = 360
) (
    input  logic                                clk_25MHz,
    input  logic                                rst,
    input  logic [race_pkg::COORD_W-1:0]        p1_x,
    input  logic [race_pkg::COORD_W-1:0]        p1_y,
    input  logic [race_pkg::COORD_W-1:0]        p2_x,
    input  logic [race_pkg::COORD_W-1:0]        p2_y,
    input  logic [race_pkg::COLOR_IDX_W-1:0]    map_idx_0,
    input  logic [race_pkg::COLOR_IDX_W-1:0]    map_idx_1,
    output logic [race_pkg::MAP_ADDR_W-1:0]     map_addr_0,
    output logic [race_pkg::MAP_ADDR_W-1:0]     map_addr_1,
    output logic [3:0]                          vga_red,
    output logic [3:0]                          vga_green,
    output logic [3:0]                          vga_blue,
    output logic                                hsync,
    output logic                                vsync
);
    import race_pkg::*;

    logic [COORD_W-1:0]          h_cnt, v_cnt;
    logic                        visible, in_hud, hsync_raw, vsync_raw;
    logic [1:0][COORD_W-1:0]     own_x, own_y, other_x, other_y;
    logic [1:0][MAP_ADDR_W-1:0]  map_addr;
    logic [1:0][COLOR_IDX_W-1:0] map_idx;
    logic [1:0]                  active, self_hit, enemy_hit, out_of_map;
    logic [RGB_W-1:0]            rgb;

    assign map_addr_0 = map_addr[0];
    assign map_addr_1 = map_addr[1];
    assign map_idx[0] = map_idx_0;
    assign map_idx[1] = map_idx_1;
    assign vga_red    = rgb[11:8];
    assign vga_green  = rgb[7:4];
    assign vga_blue   = rgb[3:0];

    scan_timing #(.HUD_TOP(HUD_TOP)) u_timing (
        .clk_25MHz(clk_25MHz), .rst(rst),
        .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y),
        .h_cnt(h_cnt), .v_cnt(v_cnt),
        .visible(visible), .in_hud(in_hud),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .own_x(own_x), .own_y(own_y), .other_x(other_x), .other_y(other_y)
    );

    // one view per half screen
    for (genvar i = 0; i < 2; i++) begin : g_view
        player_view #(.VIEW_ID(i)) u_view (
            .clk_25MHz(clk_25MHz), .rst(rst),
            .h_cnt(h_cnt), .v_cnt(v_cnt),
            .own_x(own_x[i]), .own_y(own_y[i]),
            .other_x(other_x[i]), .other_y(other_y[i]),
            .map_addr(map_addr[i]),
            .active(active[i]), .self_hit(self_hit[i]),
            .enemy_hit(enemy_hit[i]), .out_of_map(out_of_map[i])
        );
    end

    // latched positions come back through view 0 fan-out
    pixel_compositor #(.HUD_TOP(HUD_TOP)) u_comp (
        .clk_25MHz(clk_25MHz), .rst(rst),
        .h_cnt(h_cnt), .v_cnt(v_cnt),
        .visible(visible), .in_hud(in_hud),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .p1_x(own_x[0]), .p1_y(own_y[0]), .p2_x(other_x[0]), .p2_y(other_y[0]),
        .active(active), .self_hit(self_hit),
        .enemy_hit(enemy_hit), .out_of_map(out_of_map),
        .map_idx(map_idx),
        .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

endmodule

// ==== files.f ====
design/race_pkg.sv
design/scan_timing.sv
design/player_view.sv
design/pixel_compositor.sv
design/split_screen_top.sv
sim/render_chk.sv
sim/pixel_checker.sv
sim/tb_top.sv

// ==== sim/pixel_checker.sv ====
`timescale 1ns/1ps

module pixel_checker #(
    parameter int HUD_TOP = 360
) (
    input  logic                            clk_25MHz,
    input  logic                            rst,
    input  logic [race_pkg::COORD_W-1:0]    p1_x,
    input  logic [race_pkg::COORD_W-1:0]    p1_y,
    input  logic [race_pkg::COORD_W-1:0]    p2_x,
    input  logic [race_pkg::COORD_W-1:0]    p2_y,
    input  logic [race_pkg::MAP_ADDR_W-1:0] map_addr_0,
    input  logic [race_pkg::MAP_ADDR_W-1:0] map_addr_1,
    input  logic [3:0]                      vga_red,
    input  logic [3:0]                      vga_green,
    input  logic [3:0]                      vga_blue,
    input  logic                            hsync,
    input  logic                            vsync,
    output int                              errors,
    output int                              checked
);
    import race_pkg::*;

    int   n;
    logic run;
    int   mh, mv;
    int   lp1x, lp1y, lp2x, lp2y;

    function automatic bit on_dot(input int ax, input int ay, input int bx, input int by);
        return (ax - bx <= DOT_HALF) && (bx - ax <= DOT_HALF) &&
               (ay - by <= DOT_HALF) && (by - ay <= DOT_HALF);
    endfunction

    function automatic logic [RGB_W-1:0] model_rgb(input int h, input int v);
        int          sel, rel, ox, oy, rx, ry, cx, cy, ex, ey, mx, my;
        logic [16:0] a;
        if (h >= H_VISIBLE || v >= V_VISIBLE) return COL_BLANK;
        if (v == HUD_TOP - 1 || v == HUD_TOP) return COL_SEPARATOR;
        if (v > HUD_TOP) begin
            if (h < MM_X0 || h >= MM_X1) return COL_HUD;
            mx = 2 * (h - MM_X0);
            my = 2 * (v - HUD_TOP);
            if (on_dot(mx, my, lp1x, lp1y)) return COL_P1;
            if (on_dot(mx, my, lp2x, lp2y)) return COL_P2;
            return COL_HUD;
        end
        if (h == VIEW_W - 1 || h == VIEW_W) return COL_SEPARATOR;
        sel = (h >= VIEW_W) ? 1 : 0;
        rel = h - sel * VIEW_W;
        ox = sel ? lp2x : lp1x;
        oy = sel ? lp2y : lp1y;
        rx = sel ? lp1x : lp2x;
        ry = sel ? lp1y : lp2y;
        if (rel >= SELF_X0 && rel <= SELF_X1 && v >= SELF_Y0 && v <= SELF_Y1)
            return sel ? COL_P2 : COL_P1;
        ex = ENEMY_CX + 8 * (rx - ox);
        ey = ENEMY_CY + 8 * (ry - oy);
        if (rel - ex <= CAR_HALF && ex - rel <= CAR_HALF &&
            v - ey <= CAR_HALF && ey - v <= CAR_HALF)
            return sel ? COL_P1 : COL_P2;
        cx = (rel >> CELL_SHIFT) + ox - VIEW_OFS_X;
        cy = (v >> CELL_SHIFT) + oy - VIEW_OFS_Y;
        if (cx < 0 || cx >= MAP_W || cy < 0 || cy >= MAP_H) return COL_OUT_BOUND;
        a = 17'(cy * MAP_W + cx);
        return palette(a[3:0] ^ a[8:5]);
    endfunction

    // address from the view that owns pixel (h,v), 0 off the map
    function automatic int model_addr(input int h, input int v);
        int sel, ox, oy, cx, cy;
        sel = (h >= VIEW_W) ? 1 : 0;
        ox = sel ? lp2x : lp1x;
        oy = sel ? lp2y : lp1y;
        cx = ((h - sel * VIEW_W) >> CELL_SHIFT) + ox - VIEW_OFS_X;
        cy = (v >> CELL_SHIFT) + oy - VIEW_OFS_Y;
        if (cx < 0 || cx >= MAP_W || cy < 0 || cy >= MAP_H) return 0;
        return cy * MAP_W + cx;
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        if (errors <= 20) $display("Error at %0t: %s", $time, msg);
    endtask

    // positions are taken when the DUT counters wrap 3 cycles ahead of the ports
    always @(posedge clk_25MHz) begin
        if (rst) begin
            n <= 0;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (n < 3) n <= n + 1;
        end
        if (rst || (n == 3 && mh == H_TOTAL - 3 && mv == V_TOTAL - 1)) begin
            lp1x <= int'(p1_x);
            lp1y <= int'(p1_y);
            lp2x <= int'(p2_x);
            lp2y <= int'(p2_y);
        end
    end

    initial begin
        errors = 0;
        checked = 0;
        mh = 0;
        mv = 0;
    end

    always @(negedge clk_25MHz) begin
        logic [RGB_W-1:0]      exp_rgb;
        logic                  exp_hs, exp_vs;
        logic [MAP_ADDR_W-1:0] got_addr;
        int                    ah, av;
        if (run && n < 3) begin
            if ({vga_red, vga_green, vga_blue} !== COL_BLANK || hsync !== 1'b1 ||
                vsync !== 1'b1)
                flag_mismatch("outputs not idle before the first pixel");
        end else if (run) begin
            exp_rgb = model_rgb(mh, mv);
            exp_hs = !(mh >= H_VISIBLE + H_FRONT && mh < H_VISIBLE + H_FRONT + H_SYNC);
            exp_vs = !(mv >= V_VISIBLE + V_FRONT && mv < V_VISIBLE + V_FRONT + V_SYNC);
            checked++;
            if ({vga_red, vga_green, vga_blue} !== exp_rgb)
                flag_mismatch($sformatf("pixel (%0d,%0d) rgb %h, expected %h", mh, mv,
                                        {vga_red, vga_green, vga_blue}, exp_rgb));
            if (hsync !== exp_hs || vsync !== exp_vs)
                flag_mismatch($sformatf("pixel (%0d,%0d) syncs %b%b, expected %b%b",
                                        mh, mv, hsync, vsync, exp_hs, exp_vs));
            // map address runs 2 pixels ahead of the ports
            ah = mh + 2;
            av = mv;
            if (ah >= H_TOTAL) begin
                ah = ah - H_TOTAL;
                av = (av == V_TOTAL - 1) ? 0 : av + 1;
            end
            if (ah < H_VISIBLE && av < V_VISIBLE) begin
                got_addr = (ah >= VIEW_W) ? map_addr_1 : map_addr_0;
                if (got_addr !== MAP_ADDR_W'(model_addr(ah, av)))
                    flag_mismatch($sformatf("map address for (%0d,%0d) is %0d, expected %0d",
                                            ah, av, got_addr, model_addr(ah, av)));
            end
            mh = mh + 1;
            if (mh == H_TOTAL) begin
                mh = 0;
                mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
            end
        end
    end

endmodule

// ==== sim/render_chk.sv ====
`timescale 1ns/1ps

module render_chk (
    input logic       clk_25MHz,
    input logic       rst,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] vga_red,
    input logic [3:0] vga_green,
    input logic [3:0] vga_blue
);
    logic [7:0]  hs_low;
    logic [11:0] vs_low;
    // failed assertions so far
    int          fails = 0;

    // length of the current sync pulse in cycles
    always @(posedge clk_25MHz) begin
        if (rst) begin
            hs_low <= '0;
            vs_low <= '0;
        end else begin
            hs_low <= hsync ? 8'd0 : hs_low + 8'd1;
            vs_low <= vsync ? 12'd0 : vs_low + 12'd1;
        end
    end

    a_hsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(hsync) |-> hs_low == 8'd96)
        else begin
            fails++;
            $error("hsync pulse is not 96 cycles wide");
        end

    // two lines of 800 cycles
    a_vsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(vsync) |-> vs_low == 12'd1600)
        else begin
            fails++;
            $error("vsync pulse is not 2 lines wide");
        end

    a_sync_blank: assert property (@(posedge clk_25MHz) disable iff (rst)
        (!hsync || !vsync) |-> {vga_red, vga_green, vga_blue} == 12'h000)
        else begin
            fails++;
            $error("colour is not black during a sync pulse");
        end

    a_reset_values: assert property (@(posedge clk_25MHz)
        rst |=> (hsync && vsync && {vga_red, vga_green, vga_blue} == 12'h000))
        else begin
            fails++;
            $error("outputs not at reset values during reset");
        end

endmodule

bind split_screen_top render_chk u_render_chk (
    .clk_25MHz(clk_25MHz), .rst(rst), .hsync(hsync), .vsync(vsync),
    .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue)
);

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import race_pkg::*;

    localparam int HUD_TOP      = 360;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 5 * FRAME_CYCLES;

    logic                   clk_25MHz;
    logic                   rst;
    logic [COORD_W-1:0]     p1_x, p1_y, p2_x, p2_y;
    logic [COLOR_IDX_W-1:0] map_idx_0, map_idx_1;
    logic [MAP_ADDR_W-1:0]  map_addr_0, map_addr_1;
    logic [3:0]             vga_red, vga_green, vga_blue;
    logic                   hsync, vsync;
    logic [31:0]            lfsr;
    int                     errors, checked, cycles;

    split_screen_top #(.HUD_TOP(HUD_TOP)) dut0 (
        .clk_25MHz(clk_25MHz), .rst(rst),
        .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y),
        .map_idx_0(map_idx_0), .map_idx_1(map_idx_1),
        .map_addr_0(map_addr_0), .map_addr_1(map_addr_1),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
        .hsync(hsync), .vsync(vsync)
    );

    pixel_checker #(.HUD_TOP(HUD_TOP)) u_checker (
        .clk_25MHz(clk_25MHz), .rst(rst),
        .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y),
        .map_addr_0(map_addr_0), .map_addr_1(map_addr_1),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
        .hsync(hsync), .vsync(vsync), .errors(errors), .checked(checked)
    );

    initial clk_25MHz = 1'b0;
    always #20 clk_25MHz = ~clk_25MHz;

    // ----------------------------------------------------------------------
    // map memory as a synchronous ROM
    // ----------------------------------------------------------------------
    function automatic logic [COLOR_IDX_W-1:0] rom_word(input logic [MAP_ADDR_W-1:0] a);
        logic [MAP_ADDR_W-1:0] t;
        t = a ^ (a >> 5);
        return t[COLOR_IDX_W-1:0];
    endfunction

    always @(posedge clk_25MHz) begin
        map_idx_0 <= rom_word(map_addr_0);
        map_idx_1 <= rom_word(map_addr_1);
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic drive_positions(input int x1, input int y1, input int x2, input int y2);
        p1_x = 10'(x1);
        p1_y = 10'(y1);
        p2_x = 10'(x2);
        p2_y = 10'(y2);
    endtask

    // x up to 399 and y up to 299 reach past the map edges
    task automatic drive_random();
        int x1, y1, x2, y2;
        take_bits(9, x1);
        take_bits(9, y1);
        take_bits(9, x2);
        take_bits(9, y2);
        drive_positions(x1 > 399 ? x1 - 112 : x1, y1 > 299 ? y1 - 212 : y1,
                        x2 > 399 ? x2 - 112 : x2, y2 > 299 ? y2 - 212 : y2);
    endtask

    task automatic drive_edges();
        int a, b, c, d;
        take_bits(3, a);
        take_bits(3, b);
        take_bits(6, c);
        take_bits(5, d);
        drive_positions(a, b, 312 + c, 232 + d);
    endtask

    task automatic drive_overlap();
        int x, y, dx, dy;
        take_bits(8, x);
        take_bits(7, y);
        take_bits(2, dx);
        take_bits(2, dy);
        drive_positions(x + 20, y + 20, x + 20 + dx, y + 20 + dy);
    endtask

    task automatic wait_lines(input int lines);
        repeat (lines) @(negedge hsync);
    endtask

    always @(posedge clk_25MHz) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        cycles = 0;
        rst = 1'b1;
        lfsr = 32'h274b_371e;
        map_idx_0 = '0;
        map_idx_1 = '0;
        drive_random();
        repeat (RESET_CYCLES) @(negedge clk_25MHz);
        rst = 1'b0;
        // each change lands mid-frame and shows from the next frame
        wait_lines(200);
        @(negedge clk_25MHz);
        drive_edges();
        @(negedge vsync);
        wait_lines(240);
        @(negedge clk_25MHz);
        drive_positions(5, 5, 380, 280);
        @(negedge vsync);
        wait_lines(240);
        @(negedge clk_25MHz);
        drive_overlap();
        @(negedge vsync);
        wait_lines(240);
        @(negedge clk_25MHz);
        drive_random();
        @(negedge vsync);
        wait_lines(40);
        $display("checked %0d pixels, %0d errors, %0d assertion failures", checked, errors,
                 dut0.u_render_chk.fails);
        if (errors == 0 && dut0.u_render_chk.fails == 0 &&
            checked >= 4 * FRAME_CYCLES) begin
            $display("Verification passed");
        end else begin
            if (checked < 4 * FRAME_CYCLES)
                $display("too few pixels were compared");
            $display("Verification failed");
        end
        $finish;
    end

endmodule
